//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rename_tb -f list.f

sim:
	verilator --binary --timing -j 0 --top-module rename_tb -f list.f
	./obj_dir/Vrename_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- free_list.sv
`default_nettype none

module free_list (
  input  wire                     clock,
  input  wire                     rst_n,
  input  wire                     alloc_en,
  input  wire                     free_en,
  input  wire rename_pkg::pr_tag_t free_tag,
  output rename_pkg::pr_tag_t     alloc_tag,
  output logic                    empty
);

  rename_pkg::pr_tag_t fl_q [rename_pkg::num_fl];
  rename_pkg::fl_ptr_t head;
  rename_pkg::fl_ptr_t tail;
  logic [$clog2(rename_pkg::num_fl):0] count;

  assign alloc_tag = fl_q[head];
  assign empty     = (count == '0);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      // Refill with every tag above the identity mapping
      for (int i = 0; i < rename_pkg::num_fl; i++) begin
        fl_q[i] <= rename_pkg::pr_tag_t'(rename_pkg::num_arch + i);
      end
    end else if (free_en) begin
      fl_q[tail] <= free_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= ($clog2(rename_pkg::num_fl) + 1)'(rename_pkg::num_fl);
    end else begin
      if (alloc_en) begin
        head <= head + 1'b1;
      end
      if (free_en) begin
        tail <= tail + 1'b1;
      end
      case ({alloc_en, free_en})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;  // Pop and push cancel
      endcase
    end
  end

endmodule

`default_nettype wire

//--- list.f
rename_pkg.sv
free_list.sv
map_table.sv
rob.sv
phys_regfile.sv
rename_top.sv
rename_tb.sv

//--- map_table.sv
`default_nettype none

module map_table (
  input  wire                       clock,
  input  wire                       rst_n,
  input  wire                       rename_en,
  input  wire rename_pkg::arch_idx_t rename_dest,
  input  wire rename_pkg::pr_tag_t   rename_tag,
  output rename_pkg::pr_tag_t       old_tag
);

  // Speculative mapping, one tag per architectural register
  rename_pkg::pr_tag_t map_q [rename_pkg::num_arch];

  // Mapping before this cycle's rename
  assign old_tag = map_q[rename_dest];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::num_arch; i++) begin
        map_q[i] <= rename_pkg::pr_tag_t'(i);  // Identity
      end
    end else if (rename_en) begin
      map_q[rename_dest] <= rename_tag;
    end
  end

endmodule

`default_nettype wire

//--- phys_regfile.sv
`default_nettype none

module phys_regfile (
  input  wire                      clock,
  input  wire                      rst_n,
  input  wire                      wr_en,
  input  wire rename_pkg::pr_tag_t wr_tag,
  input  wire rename_pkg::word_t   wr_data,
  input  wire rename_pkg::pr_tag_t rd_tag,
  output rename_pkg::word_t        rd_data
);

  rename_pkg::word_t regs [rename_pkg::num_pr];

  assign rd_data = regs[rd_tag];  // Commit read, no bypass

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::num_pr; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_tag] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- rename_pkg.sv
`default_nettype none

package rename_pkg;

  localparam int num_arch = 32;
  localparam int num_pr   = 64;
  localparam int num_fl   = num_pr - num_arch;  // Tags not mapped at reset
  localparam int num_rob  = 16;

  typedef logic [$clog2(num_arch)-1:0] arch_idx_t;
  typedef logic [$clog2(num_pr)-1:0]   pr_tag_t;
  typedef logic [$clog2(num_rob)-1:0]  rob_idx_t;
  typedef logic [$clog2(num_fl)-1:0]   fl_ptr_t;
  typedef logic [63:0]                 word_t;
  typedef logic [15:0]                 count_t;

  // Hardwired zero register, never written at commit
  localparam arch_idx_t zero_reg = 5'd31;

  typedef enum logic [1:0] {
    no_error       = 2'd0,
    halted_on_halt = 2'd1
  } error_status_t;

endpackage

`default_nettype wire

//--- rename_tb.sv
`default_nettype none

module rename_tb;

  logic                      clock;
  logic                      rst_n;
  logic                      dispatch_valid;
  rename_pkg::arch_idx_t     dispatch_dest;
  logic                      dispatch_halt;
  logic                      complete_valid;
  rename_pkg::rob_idx_t      complete_rob_idx;
  rename_pkg::word_t         complete_data;
  logic                      dispatch_ready;
  rename_pkg::rob_idx_t      dispatch_rob_idx;
  logic                      commit_valid;
  rename_pkg::arch_idx_t     commit_wr_idx;
  rename_pkg::word_t         commit_wr_data;
  logic                      commit_wr_en;
  rename_pkg::count_t        completed_insts;
  rename_pkg::error_status_t error_status;

  // Reference model
  rename_pkg::arch_idx_t exp_dest [rename_pkg::num_rob];
  rename_pkg::word_t     exp_data [rename_pkg::num_rob];
  logic                  exp_halt [rename_pkg::num_rob];
  rename_pkg::word_t     arch_val [rename_pkg::num_arch];
  rename_pkg::word_t     arch_seen [rename_pkg::num_arch];  // Written through the commit port
  rename_pkg::rob_idx_t  order_q [$];  // Slots in program order
  rename_pkg::rob_idx_t  next_slot;
  rename_pkg::count_t    retired;

  int          mismatches;
  int          other_errors;

  rename_top u_dut (
    .clock            (clock),
    .rst_n            (rst_n),
    .dispatch_valid   (dispatch_valid),
    .dispatch_dest    (dispatch_dest),
    .dispatch_halt    (dispatch_halt),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .complete_data    (complete_data),
    .dispatch_ready   (dispatch_ready),
    .dispatch_rob_idx (dispatch_rob_idx),
    .commit_valid     (commit_valid),
    .commit_wr_idx    (commit_wr_idx),
    .commit_wr_data   (commit_wr_data),
    .commit_wr_en     (commit_wr_en),
    .completed_insts  (completed_insts),
    .error_status     (error_status)
  );

  always #10 clock = ~clock;

  task automatic check_word(input rename_pkg::word_t actual, input rename_pkg::word_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic check_arch(input rename_pkg::arch_idx_t actual,
                            input rename_pkg::arch_idx_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic check_slot(input rename_pkg::rob_idx_t actual,
                            input rename_pkg::rob_idx_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic check_count(input rename_pkg::count_t actual, input rename_pkg::count_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic check_status(input rename_pkg::error_status_t actual,
                              input rename_pkg::error_status_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  function automatic rename_pkg::word_t random_word();
    return {$urandom, $urandom};
  endfunction

  // Each commit against the oldest slot in program order
  task automatic expect_commit();
    rename_pkg::rob_idx_t slot;
    logic                 wr_en;
    if (commit_wr_en) begin
      arch_seen[commit_wr_idx] = commit_wr_data;
    end
    if (order_q.size() == 0) begin
      $display("error at %0t: a commit appeared with no instruction due to retire", $time);
      other_errors++;
    end else begin
      slot  = order_q.pop_front();
      wr_en = !exp_halt[slot] && (exp_dest[slot] != rename_pkg::zero_reg);
      check_arch(commit_wr_idx, exp_dest[slot], "commit_wr_idx");
      check_word(commit_wr_data, exp_data[slot], "commit_wr_data");
      check_bit(commit_wr_en, wr_en, "commit_wr_en");
      check_count(completed_insts, retired, "completed_insts before commit");
      if (wr_en) begin
        arch_val[exp_dest[slot]] = exp_data[slot];
      end
      retired = retired + 1'b1;
    end
  endtask

  always @(negedge clock) begin
    if (rst_n && commit_valid) begin
      expect_commit();
    end
  end

  task automatic dispatch_one(input rename_pkg::arch_idx_t dest, input logic halt,
                              output rename_pkg::rob_idx_t slot);
    int cycles;
    cycles         = 0;
    dispatch_valid = 1'b1;
    dispatch_dest  = dest;
    dispatch_halt  = halt;
    @(negedge clock);
    while (!dispatch_ready && cycles < 200) begin
      @(negedge clock);
      cycles++;
    end
    slot = next_slot;
    if (!dispatch_ready) begin
      $display("error at %0t: dispatch was not accepted within 200 cycles", $time);
      other_errors++;
    end else begin
      check_slot(dispatch_rob_idx, next_slot, "dispatch_rob_idx");
      exp_dest[next_slot] = dest;
      exp_halt[next_slot] = halt;
      order_q.push_back(next_slot);
      next_slot = next_slot + 1'b1;  // Wraps at num_rob
    end
    @(posedge clock);
    #2;
    dispatch_valid = 1'b0;
  endtask

  task automatic complete_one(input rename_pkg::rob_idx_t slot, input rename_pkg::word_t data);
    complete_valid   = 1'b1;
    complete_rob_idx = slot;
    complete_data    = data;
    exp_data[slot]   = data;
    @(posedge clock);
    #2;
    complete_valid = 1'b0;
  endtask

  task automatic wait_commit();
    int cycles;
    cycles = 0;
    while (order_q.size() != 0 && cycles < 200) begin
      @(posedge clock);
      cycles++;
    end
    if (order_q.size() != 0) begin
      $display("error at %0t: %0d instructions never committed", $time, order_q.size());
      other_errors++;
      order_q.delete();
    end
    @(posedge clock);
    #2;
    check_count(completed_insts, retired, "completed_insts after drain");
    for (int i = 0; i < rename_pkg::num_arch; i++) begin
      check_word(arch_seen[i], arch_val[i], $sformatf("register %0d after drain", i));
    end
  endtask

  task automatic reset_state();
    rename_pkg::rob_idx_t slot;
    @(negedge clock);
    check_bit(commit_valid, 1'b0, "commit_valid after reset");
    check_bit(dispatch_ready, 1'b1, "dispatch_ready after reset");
    check_count(completed_insts, '0, "completed_insts after reset");
    check_status(error_status, rename_pkg::no_error, "error_status after reset");
    @(posedge clock);
    #2;
    dispatch_one(rename_pkg::arch_idx_t'(1), 1'b0, slot);  // Slot 0 expected
    complete_one(slot, random_word());
    wait_commit();
  endtask

  task automatic commit_in_order();
    rename_pkg::rob_idx_t slots [8];
    rename_pkg::rob_idx_t tmp;
    int                   j;
    for (int i = 0; i < 8; i++) begin
      dispatch_one(rename_pkg::arch_idx_t'(i), 1'b0, slots[i]);
    end
    for (int i = 7; i > 0; i--) begin
      j        = $urandom % (i + 1);
      tmp      = slots[i];
      slots[i] = slots[j];
      slots[j] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
      complete_one(slots[i], random_word());
    end
    wait_commit();
  endtask

  // 40 renames of one register exceed the free list depth
  task automatic reuse_one_register();
    rename_pkg::rob_idx_t slots [4];
    for (int round = 0; round < 10; round++) begin
      for (int i = 0; i < 4; i++) begin
        dispatch_one(rename_pkg::arch_idx_t'(3), 1'b0, slots[i]);
      end
      for (int i = 3; i >= 0; i--) begin
        complete_one(slots[i], random_word());
      end
      wait_commit();
    end
  endtask

  task automatic retire_zero_reg();
    rename_pkg::rob_idx_t slot;
    dispatch_one(rename_pkg::zero_reg, 1'b0, slot);
    complete_one(slot, random_word());
    wait_commit();
  endtask

  task automatic fill_rob();
    rename_pkg::rob_idx_t slots [rename_pkg::num_rob + 1];
    for (int i = 0; i < rename_pkg::num_rob; i++) begin
      dispatch_one(rename_pkg::arch_idx_t'(8 + i), 1'b0, slots[i]);
    end
    dispatch_valid = 1'b1;
    dispatch_dest  = rename_pkg::arch_idx_t'(30);
    dispatch_halt  = 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_bit(dispatch_ready, 1'b0, "dispatch_ready with full ROB");
      check_slot(dispatch_rob_idx, next_slot, "dispatch_rob_idx while held");
    end
    @(posedge clock);
    #2;
    complete_one(slots[0], random_word());
    dispatch_one(rename_pkg::arch_idx_t'(30), 1'b0, slots[rename_pkg::num_rob]);
    for (int i = 1; i <= rename_pkg::num_rob; i++) begin
      complete_one(slots[i], random_word());
    end
    wait_commit();
  endtask

  task automatic stop_on_halt();
    rename_pkg::rob_idx_t halt_slot;
    rename_pkg::rob_idx_t late_slot;
    dispatch_one(rename_pkg::arch_idx_t'(5), 1'b1, halt_slot);
    dispatch_one(rename_pkg::arch_idx_t'(6), 1'b0, late_slot);
    void'(order_q.pop_back());  // Entry behind the halt must never retire
    complete_one(late_slot, random_word());
    complete_one(halt_slot, random_word());
    wait_commit();
    check_status(error_status, rename_pkg::halted_on_halt, "error_status after halt");
    repeat (200) begin
      @(negedge clock);
      check_bit(dispatch_ready, 1'b0, "dispatch_ready while halted");
    end
    check_status(error_status, rename_pkg::halted_on_halt, "error_status at end");
  endtask

  initial begin
    void'($urandom(39));
    clock            = 1'b0;
    rst_n            = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch_dest    = '0;
    dispatch_halt    = 1'b0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    complete_data    = '0;
    next_slot        = '0;
    retired          = '0;
    mismatches       = 0;
    other_errors     = 0;
    for (int i = 0; i < rename_pkg::num_arch; i++) begin
      arch_val[i]  = '0;
      arch_seen[i] = '0;
    end
    repeat (3) @(posedge clock);
    #2;
    rst_n = 1'b1;

    reset_state();
    commit_in_order();
    reuse_one_register();
    retire_zero_reg();
    fill_rob();
    stop_on_halt();

    $display("%0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rename_top.sv
`default_nettype none

module rename_top (
  input  wire                        clock,
  input  wire                        rst_n,
  input  wire                        dispatch_valid,
  input  wire rename_pkg::arch_idx_t dispatch_dest,
  input  wire                        dispatch_halt,
  input  wire                        complete_valid,
  input  wire rename_pkg::rob_idx_t  complete_rob_idx,
  input  wire rename_pkg::word_t     complete_data,
  output logic                       dispatch_ready,
  output rename_pkg::rob_idx_t       dispatch_rob_idx,
  output logic                       commit_valid,
  output rename_pkg::arch_idx_t      commit_wr_idx,
  output rename_pkg::word_t          commit_wr_data,
  output logic                       commit_wr_en,
  output rename_pkg::count_t         completed_insts,
  output rename_pkg::error_status_t  error_status
);

  logic                  dispatch_en;
  logic                  rob_full;
  logic                  fl_empty;
  logic                  halted;
  rename_pkg::pr_tag_t   new_tag;
  rename_pkg::pr_tag_t   old_tag;
  rename_pkg::pr_tag_t   pr_wr_tag;
  logic                  retire_en;
  rename_pkg::arch_idx_t retire_dest;
  rename_pkg::pr_tag_t   retire_tag;
  rename_pkg::pr_tag_t   retire_old_tag;
  logic                  retire_halt;

  assign dispatch_ready = !rob_full && !fl_empty && !halted;
  assign dispatch_en    = dispatch_valid && dispatch_ready;

  free_list u_free_list (
    .clock     (clock),
    .rst_n     (rst_n),
    .alloc_en  (dispatch_en),
    .free_en   (retire_en),
    .free_tag  (retire_old_tag),   // Previous mapping goes back
    .alloc_tag (new_tag),
    .empty     (fl_empty)
  );

  map_table u_map_table (
    .clock       (clock),
    .rst_n       (rst_n),
    .rename_en   (dispatch_en),
    .rename_dest (dispatch_dest),
    .rename_tag  (new_tag),
    .old_tag     (old_tag)
  );

  rob u_rob (
    .clock          (clock),
    .rst_n          (rst_n),
    .alloc_en       (dispatch_en),
    .alloc_dest     (dispatch_dest),
    .alloc_tag      (new_tag),
    .alloc_old_tag  (old_tag),
    .alloc_halt     (dispatch_halt),
    .complete_en    (complete_valid),
    .complete_idx   (complete_rob_idx),
    .tail_idx       (dispatch_rob_idx),
    .full           (rob_full),
    .wr_tag         (pr_wr_tag),
    .retire_en      (retire_en),
    .retire_dest    (retire_dest),
    .retire_tag     (retire_tag),
    .retire_old_tag (retire_old_tag),
    .retire_halt    (retire_halt),
    .halted         (halted)
  );

  phys_regfile u_phys_regfile (
    .clock   (clock),
    .rst_n   (rst_n),
    .wr_en   (complete_valid),
    .wr_tag  (pr_wr_tag),
    .wr_data (complete_data),
    .rd_tag  (retire_tag),
    .rd_data (commit_wr_data)
  );

  // Commit port straight from the ROB head
  assign commit_valid  = retire_en;
  assign commit_wr_idx = retire_dest;
  assign commit_wr_en  = retire_en && !retire_halt && (retire_dest != rename_pkg::zero_reg);

  assign error_status = halted ? rename_pkg::halted_on_halt : rename_pkg::no_error;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      completed_insts <= '0;
    end else if (retire_en) begin
      completed_insts <= completed_insts + 1'b1;  // Halt entry counts too
    end
  end

endmodule

`default_nettype wire

//--- rob.sv
`default_nettype none

module rob (
  input  wire                        clock,
  input  wire                        rst_n,
  input  wire                        alloc_en,
  input  wire rename_pkg::arch_idx_t alloc_dest,
  input  wire rename_pkg::pr_tag_t   alloc_tag,
  input  wire rename_pkg::pr_tag_t   alloc_old_tag,
  input  wire                        alloc_halt,
  input  wire                        complete_en,
  input  wire rename_pkg::rob_idx_t  complete_idx,
  output rename_pkg::rob_idx_t       tail_idx,
  output logic                       full,
  output rename_pkg::pr_tag_t        wr_tag,
  output logic                       retire_en,
  output rename_pkg::arch_idx_t      retire_dest,
  output rename_pkg::pr_tag_t        retire_tag,
  output rename_pkg::pr_tag_t        retire_old_tag,
  output logic                       retire_halt,
  output logic                       halted
);

  logic                  in_use_q [rename_pkg::num_rob];
  logic                  done_q   [rename_pkg::num_rob];
  rename_pkg::arch_idx_t dest_q   [rename_pkg::num_rob];
  rename_pkg::pr_tag_t   tag_q    [rename_pkg::num_rob];
  rename_pkg::pr_tag_t   old_q    [rename_pkg::num_rob];
  logic                  halt_q   [rename_pkg::num_rob];

  rename_pkg::rob_idx_t head;
  rename_pkg::rob_idx_t tail;
  logic [$clog2(rename_pkg::num_rob):0] count;

  assign tail_idx = tail;
  assign full     = (count == ($clog2(rename_pkg::num_rob) + 1)'(rename_pkg::num_rob));
  assign wr_tag   = tag_q[complete_idx];  // Destination of the completing slot

  // Head slot drives retirement
  assign retire_en      = in_use_q[head] && done_q[head] && !halted;
  assign retire_dest    = dest_q[head];
  assign retire_tag     = tag_q[head];
  assign retire_old_tag = old_q[head];
  assign retire_halt    = halt_q[head];

  always_ff @(posedge clock) begin
    if (alloc_en) begin
      dest_q[tail] <= alloc_dest;
      tag_q[tail]  <= alloc_tag;
      old_q[tail]  <= alloc_old_tag;
      halt_q[tail] <= alloc_halt;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::num_rob; i++) begin
        in_use_q[i] <= 1'b0;
        done_q[i]   <= 1'b0;
      end
    end else begin
      if (retire_en) begin
        in_use_q[head] <= 1'b0;
      end
      if (alloc_en) begin
        in_use_q[tail] <= 1'b1;
        done_q[tail]   <= 1'b0;
      end
      if (complete_en) begin
        done_q[complete_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head   <= '0;
      tail   <= '0;
      count  <= '0;
      halted <= 1'b0;
    end else begin
      if (alloc_en) begin
        tail <= tail + 1'b1;
      end
      if (retire_en) begin
        head <= head + 1'b1;
        if (retire_halt) begin
          halted <= 1'b1;  // Sticky until reset
        end
      end
      case ({alloc_en, retire_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire
